/* src/i2c_standby_pkg.sv */
// I2C standby bridge types
package i2c_standby_pkg;

  // Plain data byte on the bus and in the queues
  typedef logic [7:0] byte_t;

  // Transfer length or byte count
  typedef logic [15:0] xfer_len_t;

  // Event kinds reported by the I2C target controller
  typedef enum logic [2:0] {
    AcqStartWrite = 3'd0,
    AcqStartRead  = 3'd1,
    AcqData       = 3'd2,
    AcqStop       = 3'd3,
    AcqRestart    = 3'd4,
    AcqNack       = 3'd5
  } acq_id_e;

  // One acquisition entry, data is only meaningful for AcqData
  typedef struct packed {
    acq_id_e id;
    byte_t   data;
  } acq_entry_t;

  // Read command from the host
  typedef struct packed {
    xfer_len_t   data_length;
    logic [7:0]  tid;
  } cmd_desc_t;

  // Response status codes
  typedef enum logic [1:0] {
    RespOk        = 2'd0,
    RespOverflow  = 2'd1,
    RespBadLength = 2'd2,
    RespNack      = 2'd3
  } resp_err_e;

  // Response to the host, tid is zero for writes
  typedef struct packed {
    xfer_len_t   data_length;
    resp_err_e   err_status;
    logic [7:0]  tid;
  } resp_desc_t;

endpackage

/* src/sync_fifo.sv */
// Synchronous FIFO
`timescale 1ns/1ns

module sync_fifo #(
  parameter int Width = 8,
  parameter int Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  input  logic [Width-1:0] wdata_i,
  output logic             wready_o,
  output logic             rvalid_o,
  output logic [Width-1:0] rdata_o,
  input  logic             rready_i
);
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q, rptr_q;
  logic [CntW-1:0]  count_q;
  logic             push, pop;

  assign wready_o = (count_q != CntW'(Depth));
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  // Storage, no reset needed on payload
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Push and pop in one cycle leave the occupancy unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* src/standby_flow_fsm.sv */
// Standby flow engine
`timescale 1ns/1ns

module standby_flow_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Acquisition stream from the I2C target controller
  input  logic                        acq_valid_i,
  input  i2c_standby_pkg::acq_entry_t acq_i,

  // Command queue read side
  input  logic                        cmd_valid_i,
  input  i2c_standby_pkg::cmd_desc_t  cmd_i,
  output logic                        cmd_ready_o,

  // Transmit queue read side
  input  logic                        txq_valid_i,
  input  i2c_standby_pkg::byte_t      txq_data_i,
  output logic                        txq_ready_o,

  // Byte out to the controller
  output logic                        tx_valid_o,
  output i2c_standby_pkg::byte_t      tx_byte_o,
  input  logic                        tx_ready_i,

  // Receive queue write side
  output logic                        rx_valid_o,
  output i2c_standby_pkg::byte_t      rx_data_o,
  input  logic                        rx_ready_i,

  // Response queue write side
  output logic                        resp_valid_o,
  output i2c_standby_pkg::resp_desc_t resp_o,
  input  logic                        resp_ready_i,

  output logic                        err_o
);
  typedef enum logic [3:0] {
    AwaitStart          = 4'd0,
    ReceiveByte         = 4'd1,
    PopCommand          = 4'd2,
    FetchByte           = 4'd3,
    SendByte            = 4'd4,
    AwaitStop           = 4'd5,
    ReportError         = 4'd6,
    AwaitStopAfterError = 4'd7,
    PushResponse        = 4'd8
  } state_e;

  state_e state_q, state_d;

  // Transfer bookkeeping
  i2c_standby_pkg::xfer_len_t byte_cnt_q;
  i2c_standby_pkg::xfer_len_t len_q;
  logic [7:0]                 tid_q;
  i2c_standby_pkg::resp_err_e status_q;

  // Registered bytes toward the queues and the controller
  logic                       rx_valid_q;
  i2c_standby_pkg::byte_t     rx_data_q;
  i2c_standby_pkg::byte_t     tx_byte_q;

  // Decoded events
  logic is_start_wr, is_start_rd, is_data, is_end, is_nack;

  logic xfer_start;
  logic rx_accept, rx_overflow;
  logic cmd_fire, txq_fire, tx_fire, tx_last;
  logic err_set;
  i2c_standby_pkg::resp_err_e err_code;
  state_e start_state;

  assign is_start_wr = acq_valid_i && (acq_i.id == i2c_standby_pkg::AcqStartWrite);
  assign is_start_rd = acq_valid_i && (acq_i.id == i2c_standby_pkg::AcqStartRead);
  assign is_data     = acq_valid_i && (acq_i.id == i2c_standby_pkg::AcqData);
  assign is_nack     = acq_valid_i && (acq_i.id == i2c_standby_pkg::AcqNack);
  assign is_end      = acq_valid_i && ((acq_i.id == i2c_standby_pkg::AcqStop) ||
                                       (acq_i.id == i2c_standby_pkg::AcqRestart));

  // Where a start takes us, also used when leaving PushResponse
  always_comb begin
    if (is_start_wr) begin
      start_state = ReceiveByte;
    end else if (is_start_rd) begin
      start_state = PopCommand;
    end else begin
      start_state = AwaitStart;
    end
  end

  assign xfer_start = (is_start_wr || is_start_rd) &&
                      ((state_q == AwaitStart) ||
                       ((state_q == PushResponse) && resp_ready_i));

  // A byte is taken only while the receive queue has room
  assign rx_accept   = (state_q == ReceiveByte) && is_data && rx_ready_i;
  assign rx_overflow = (state_q == ReceiveByte) && is_data && !rx_ready_i;

  assign cmd_ready_o = (state_q == PopCommand);
  assign cmd_fire    = cmd_ready_o && cmd_valid_i;

  // No prefetch once the controller has given a NACK
  assign txq_ready_o = (state_q == FetchByte) && !is_nack;
  assign txq_fire    = txq_ready_o && txq_valid_i;

  assign tx_valid_o = (state_q == SendByte);
  assign tx_byte_o  = tx_byte_q;
  assign tx_fire    = tx_valid_o && tx_ready_i;
  assign tx_last    = ((byte_cnt_q + 16'd1) == len_q);

  assign rx_valid_o = rx_valid_q;
  assign rx_data_o  = rx_data_q;

  assign resp_valid_o       = (state_q == PushResponse);
  assign resp_o.data_length = byte_cnt_q;
  assign resp_o.err_status  = status_q;
  assign resp_o.tid         = tid_q;

  assign err_o = (state_q == ReportError);

  always_comb begin
    state_d  = state_q;
    err_set  = 1'b0;
    err_code = i2c_standby_pkg::RespOk;
    unique case (state_q)
      AwaitStart: begin
        state_d = start_state;
      end
      ReceiveByte: begin
        if (is_end) begin
          state_d = PushResponse;
        end else if (rx_overflow) begin
          state_d  = ReportError;
          err_set  = 1'b1;
          err_code = i2c_standby_pkg::RespOverflow;
        end
      end
      PopCommand: begin
        if (is_nack) begin
          state_d  = ReportError;
          err_set  = 1'b1;
          err_code = i2c_standby_pkg::RespNack;
        end else if (cmd_valid_i) begin
          if (cmd_i.data_length == '0) begin
            state_d  = ReportError;
            err_set  = 1'b1;
            err_code = i2c_standby_pkg::RespBadLength;
          end else begin
            state_d = FetchByte;
          end
        end
      end
      FetchByte: begin
        if (is_nack) begin
          state_d  = ReportError;
          err_set  = 1'b1;
          err_code = i2c_standby_pkg::RespNack;
        end else if (txq_valid_i) begin
          state_d = SendByte;
        end
      end
      SendByte: begin
        // NACK withdraws the offered byte unless it completes the read
        if (is_nack && !(tx_fire && tx_last)) begin
          state_d  = ReportError;
          err_set  = 1'b1;
          err_code = i2c_standby_pkg::RespNack;
        end else if (tx_fire) begin
          state_d = tx_last ? AwaitStop : FetchByte;
        end
      end
      AwaitStop: begin
        // A NACK on the last byte is normal here
        if (is_end) begin
          state_d = PushResponse;
        end
      end
      ReportError: begin
        state_d = is_end ? PushResponse : AwaitStopAfterError;
      end
      AwaitStopAfterError: begin
        if (is_end) begin
          state_d = PushResponse;
        end
      end
      PushResponse: begin
        if (resp_ready_i) begin
          state_d = start_state;
        end
      end
      default: begin
        state_d = AwaitStart;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AwaitStart;
    end else begin
      state_q <= state_d;
    end
  end

  // Byte count, command fields and status of the current transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
      len_q      <= '0;
      tid_q      <= '0;
      status_q   <= i2c_standby_pkg::RespOk;
    end else begin
      if (xfer_start) begin
        byte_cnt_q <= '0;
        len_q      <= '0;
        tid_q      <= '0;
        status_q   <= i2c_standby_pkg::RespOk;
      end else begin
        if (rx_accept || tx_fire) begin
          byte_cnt_q <= byte_cnt_q + 16'd1;
        end
        if (cmd_fire) begin
          len_q <= cmd_i.data_length;
          tid_q <= cmd_i.tid;
        end
        if (err_set) begin
          status_q <= err_code;
        end
      end
    end
  end

  // Push toward the receive queue, held until taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_valid_q <= 1'b0;
    end else if (rx_accept) begin
      rx_valid_q <= 1'b1;
    end else if (rx_ready_i) begin
      rx_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_accept) begin
      rx_data_q <= acq_i.data;
    end
    if (txq_fire) begin
      tx_byte_q <= txq_data_i;
    end
  end

endmodule

/* src/i2c_standby_bridge.sv */
// I2C standby bridge top
`timescale 1ns/1ns

module i2c_standby_bridge #(
  parameter int RxDepth   = 8,
  parameter int TxDepth   = 8,
  parameter int CmdDepth  = 4,
  parameter int RespDepth = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Acquisition stream, no back-pressure
  input  logic                        acq_valid_i,
  input  i2c_standby_pkg::acq_entry_t acq_i,

  // Byte out to the controller
  output logic                        tx_valid_o,
  output i2c_standby_pkg::byte_t      tx_byte_o,
  input  logic                        tx_ready_i,

  // Host queues
  input  logic                        cmd_valid_i,
  input  i2c_standby_pkg::cmd_desc_t  cmd_i,
  output logic                        cmd_ready_o,
  input  logic                        txq_valid_i,
  input  i2c_standby_pkg::byte_t      txq_data_i,
  output logic                        txq_ready_o,
  output logic                        rxq_valid_o,
  output i2c_standby_pkg::byte_t      rxq_data_o,
  input  logic                        rxq_ready_i,
  output logic                        resp_valid_o,
  output i2c_standby_pkg::resp_desc_t resp_o,
  input  logic                        resp_ready_i,

  output logic                        err_o
);
  // Engine side of the queues
  logic                        cmd_rvalid, cmd_rready;
  i2c_standby_pkg::cmd_desc_t  cmd_rdata;
  logic                        txq_rvalid, txq_rready;
  i2c_standby_pkg::byte_t      txq_rdata;
  logic                        rx_wvalid, rx_wready;
  i2c_standby_pkg::byte_t      rx_wdata;
  logic                        resp_wvalid, resp_wready;
  i2c_standby_pkg::resp_desc_t resp_wdata;

  standby_flow_fsm u_flow_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acq_valid_i  (acq_valid_i),
    .acq_i        (acq_i),
    .cmd_valid_i  (cmd_rvalid),
    .cmd_i        (cmd_rdata),
    .cmd_ready_o  (cmd_rready),
    .txq_valid_i  (txq_rvalid),
    .txq_data_i   (txq_rdata),
    .txq_ready_o  (txq_rready),
    .tx_valid_o   (tx_valid_o),
    .tx_byte_o    (tx_byte_o),
    .tx_ready_i   (tx_ready_i),
    .rx_valid_o   (rx_wvalid),
    .rx_data_o    (rx_wdata),
    .rx_ready_i   (rx_wready),
    .resp_valid_o (resp_wvalid),
    .resp_o       (resp_wdata),
    .resp_ready_i (resp_wready),
    .err_o        (err_o)
  );

  // Host pushes commands, the engine pops them
  sync_fifo #(
    .Width ($bits(i2c_standby_pkg::cmd_desc_t)),
    .Depth (CmdDepth)
  ) u_cmd_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (cmd_valid_i),
    .wdata_i  (cmd_i),
    .wready_o (cmd_ready_o),
    .rvalid_o (cmd_rvalid),
    .rdata_o  (cmd_rdata),
    .rready_i (cmd_rready)
  );

  sync_fifo #(
    .Width ($bits(i2c_standby_pkg::byte_t)),
    .Depth (TxDepth)
  ) u_tx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (txq_valid_i),
    .wdata_i  (txq_data_i),
    .wready_o (txq_ready_o),
    .rvalid_o (txq_rvalid),
    .rdata_o  (txq_rdata),
    .rready_i (txq_rready)
  );

  // Engine pushes received bytes and responses, the host pops them
  sync_fifo #(
    .Width ($bits(i2c_standby_pkg::byte_t)),
    .Depth (RxDepth)
  ) u_rx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rx_wvalid),
    .wdata_i  (rx_wdata),
    .wready_o (rx_wready),
    .rvalid_o (rxq_valid_o),
    .rdata_o  (rxq_data_o),
    .rready_i (rxq_ready_i)
  );

  sync_fifo #(
    .Width ($bits(i2c_standby_pkg::resp_desc_t)),
    .Depth (RespDepth)
  ) u_resp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (resp_wvalid),
    .wdata_i  (resp_wdata),
    .wready_o (resp_wready),
    .rvalid_o (resp_valid_o),
    .rdata_o  (resp_o),
    .rready_i (resp_ready_i)
  );

endmodule

/* tb/i2c_standby_bridge_sva.sv */
// Bridge handshake assertions
`timescale 1ns/1ns

module i2c_standby_bridge_sva (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        tx_valid_o,
  input i2c_standby_pkg::byte_t      tx_byte_o,
  input logic                        tx_ready_i,
  input logic                        resp_valid_o,
  input i2c_standby_pkg::resp_desc_t resp_o,
  input logic                        resp_ready_i,
  input logic                        rxq_valid_o,
  input logic                        err_o
);
  // Number of failed assertions
  int fail_cnt = 0;

  // Offered byte is held while the controller stalls
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_valid_o && !tx_ready_i) |=> (tx_valid_o && $stable(tx_byte_o)))
    else begin
      $error("tx byte changed while stalled");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o)))
    else begin
      $error("response changed while stalled");
      fail_cnt++;
    end

  // Error is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) err_o |=> !err_o)
    else begin
      $error("err_o high for two cycles");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) !rst_ni |-> !(tx_valid_o || resp_valid_o || rxq_valid_o))
    else begin
      $error("output valid high during reset");
      fail_cnt++;
    end

endmodule

bind i2c_standby_bridge i2c_standby_bridge_sva u_bridge_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .tx_valid_o   (tx_valid_o),
  .tx_byte_o    (tx_byte_o),
  .tx_ready_i   (tx_ready_i),
  .resp_valid_o (resp_valid_o),
  .resp_o       (resp_o),
  .resp_ready_i (resp_ready_i),
  .rxq_valid_o  (rxq_valid_o),
  .err_o        (err_o)
);

/* tb/tb_i2c_standby_bridge.sv */
// I2C standby bridge testbench
`timescale 1ns/1ns

module tb_i2c_standby_bridge;
  localparam int RxDepth   = 8;
  localparam int TxDepth   = 8;
  localparam int CmdDepth  = 4;
  localparam int RespDepth = 4;

  // One line of the cases file
  typedef struct packed {
    logic [8*12-1:0]            kind;
    i2c_standby_pkg::xfer_len_t len;
    logic [7:0]                 tid;
    logic [7:0]                 seed;
    i2c_standby_pkg::xfer_len_t nack_at;
    i2c_standby_pkg::xfer_len_t exp_len;
    logic [1:0]                 exp_err;
  } case_t;

  logic                        clk_i, rst_ni;
  logic                        acq_valid_i;
  i2c_standby_pkg::acq_entry_t acq_i;
  logic                        tx_valid_o, tx_ready_i;
  i2c_standby_pkg::byte_t      tx_byte_o;
  logic                        cmd_valid_i, cmd_ready_o;
  i2c_standby_pkg::cmd_desc_t  cmd_i;
  logic                        txq_valid_i, txq_ready_o;
  i2c_standby_pkg::byte_t      txq_data_i;
  logic                        rxq_valid_o, rxq_ready_i;
  i2c_standby_pkg::byte_t      rxq_data_o;
  logic                        resp_valid_o, resp_ready_i;
  i2c_standby_pkg::resp_desc_t resp_o;
  logic                        err_o;

  // Reference model state
  case_t                       cases[$];
  logic [7:0]                  exp_rx[$];
  logic [7:0]                  exp_tx[$];
  i2c_standby_pkg::resp_desc_t resp_q[$];
  int                          err_cnt;
  logic                        hold_rx;

  i2c_standby_bridge #(
    .RxDepth   (RxDepth),
    .TxDepth   (TxDepth),
    .CmdDepth  (CmdDepth),
    .RespDepth (RespDepth)
  ) DUT (.*);

  always #2 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
      $display("sim failed");
      $fatal(1, "stopping on first error");
    end
  endtask

  // One acquisition entry followed by at least one idle cycle
  task automatic send_acq(input i2c_standby_pkg::acq_id_e id, input logic [7:0] data);
    @(posedge clk_i);
    #1;
    acq_valid_i = 1'b1;
    acq_i.id    = id;
    acq_i.data  = data;
    @(posedge clk_i);
    #1;
    acq_valid_i = 1'b0;
    repeat ($urandom % 2) @(posedge clk_i);
  endtask

  task automatic push_cmd(input i2c_standby_pkg::xfer_len_t len, input logic [7:0] tid);
    @(posedge clk_i);
    #1;
    cmd_valid_i         = 1'b1;
    cmd_i.data_length   = len;
    cmd_i.tid           = tid;
    @(negedge clk_i);
    while (!cmd_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
  endtask

  task automatic push_tx_byte(input logic [7:0] data);
    @(posedge clk_i);
    #1;
    txq_valid_i = 1'b1;
    txq_data_i  = data;
    @(negedge clk_i);
    while (!txq_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    txq_valid_i = 1'b0;
  endtask

  // Bytes past the expected count are dropped by the bridge
  task automatic run_write(input case_t c);
    logic [7:0] b;
    int         i;
    send_acq(i2c_standby_pkg::AcqStartWrite, 8'h00);
    for (i = 0; i < c.len; i++) begin
      b = 8'($urandom) ^ c.seed;
      if (i < c.exp_len) begin
        exp_rx.push_back(b);
      end
      send_acq(i2c_standby_pkg::AcqData, b);
    end
    if (c.kind == "restart") begin
      send_acq(i2c_standby_pkg::AcqRestart, 8'h00);
    end else begin
      send_acq(i2c_standby_pkg::AcqStop, 8'h00);
    end
  endtask

  // For NACK cases the host only supplies the bytes sent before the NACK
  task automatic run_read(input case_t c);
    logic [7:0] b;
    int         i;
    int         n_push;
    n_push = (c.kind == "nack") ? int'(c.nack_at) : int'(c.len);
    push_cmd(c.len, c.tid);
    for (i = 0; i < n_push; i++) begin
      b = 8'($urandom) ^ c.seed;
      exp_tx.push_back(b);
      push_tx_byte(b);
    end
    send_acq(i2c_standby_pkg::AcqStartRead, 8'h00);
    wait (exp_tx.size() == 0);
    if (c.kind != "zero-length") begin
      send_acq(i2c_standby_pkg::AcqNack, 8'h00);
    end
    send_acq(i2c_standby_pkg::AcqStop, 8'h00);
  endtask

  // Random back-pressure from the host and the controller
  always @(posedge clk_i) begin
    #1;
    rxq_ready_i  = hold_rx ? 1'b0 : 1'($urandom % 2);
    resp_ready_i = 1'($urandom % 2);
    tx_ready_i   = (($urandom % 4) != 0);
  end

  // Outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    if (DUT.u_bridge_sva.fail_cnt != 0) begin
      fail_run("a bound assertion failed");
    end
    if (rst_ni === 1'b1) begin
      if (err_o) begin
        err_cnt++;
      end
      if (rxq_valid_o && rxq_ready_i) begin
        if (exp_rx.size() == 0) begin
          fail_run("receive queue delivered a byte that was not expected");
        end else begin
          check_value(rxq_data_o, exp_rx.pop_front(), "receive queue byte");
        end
      end
      if (tx_valid_o && tx_ready_i) begin
        if (exp_tx.size() == 0) begin
          fail_run("controller got a byte that was not expected");
        end else begin
          check_value(tx_byte_o, exp_tx.pop_front(), "controller byte");
        end
      end
      if (resp_valid_o && resp_ready_i) begin
        resp_q.push_back(resp_o);
      end
    end
  end

  initial begin
    #1;
    repeat (cases.size() * 400) @(posedge clk_i);
    $display("timeout, the cases did not finish within %0d cycles", cases.size() * 400);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int                          fd, n, i;
    int                          len_v, tid_v, seed_v, nack_v, elen_v, eerr_v;
    int unsigned                 rng_seed;
    logic [8*12-1:0]             kind_s;
    string                       line;
    case_t                       c;
    i2c_standby_pkg::resp_desc_t r;
    logic [7:0]                  exp_tid;

    clk_i        = 1'b0;
    rst_ni       = 1'b1;
    acq_valid_i  = 1'b0;
    acq_i        = '0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    txq_valid_i  = 1'b0;
    txq_data_i   = '0;
    tx_ready_i   = 1'b0;
    rxq_ready_i  = 1'b0;
    resp_ready_i = 1'b0;
    hold_rx      = 1'b0;
    err_cnt      = 0;
    rng_seed     = 32'haa0f;
    void'($urandom(rng_seed));

    fd = $fopen("tb/bridge_cases.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the cases file");
    end
    while ($fgets(line, fd)) begin
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %d %h %h %d %d %d", kind_s, len_v, tid_v, seed_v,
                    nack_v, elen_v, eerr_v);
        if (n != 7) begin
          fail_run("malformed line in the cases file");
        end
        c = '{kind_s, 16'(len_v), 8'(tid_v), 8'(seed_v), 16'(nack_v), 16'(elen_v),
              2'(eerr_v)};
        cases.push_back(c);
      end
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      fail_run("the cases file holds no cases");
    end

    #1 rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    for (i = 0; i < cases.size(); i++) begin
      c       = cases[i];
      err_cnt = 0;
      hold_rx = (c.kind == "overflow");
      if (c.kind == "read" || c.kind == "zero-length" || c.kind == "nack") begin
        exp_tid = c.tid;
        run_read(c);
      end else begin
        exp_tid = 8'h00;
        run_write(c);
      end
      wait (resp_q.size() > 0);
      r = resp_q.pop_front();
      check_value(r.data_length, c.exp_len, "response length");
      check_value(r.err_status, c.exp_err, "response status");
      check_value(r.tid, exp_tid, "response tid");
      // Accepted bytes drain once the host pops again
      hold_rx = 1'b0;
      wait (exp_rx.size() == 0);
      repeat (4) @(posedge clk_i);
      check_value(err_cnt, (c.exp_err != 0) ? 1 : 0, "error pulse count");
    end

    repeat (4) @(posedge clk_i);
    check_value(resp_q.size(), 0, "leftover responses");
    if (DUT.u_bridge_sva.fail_cnt != 0) begin
      fail_run("a bound assertion failed");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

/* i2c_standby_bridge.f */
src/i2c_standby_pkg.sv
src/sync_fifo.sv
src/standby_flow_fsm.sv
src/i2c_standby_bridge.sv
tb/i2c_standby_bridge_sva.sv
tb/tb_i2c_standby_bridge.sv

/* tb/bridge_cases.txt */
# kind len tid seed nack_at exp_len exp_err (tid and seed in hex)
# exp_err 0 ok, 1 overflow, 2 bad length, 3 nack; nack_at is bytes sent before the NACK
write 4 00 3c 0 4 0
write 8 00 a5 0 8 0
write 1 00 00 0 1 0
read 3 11 5a 0 3 0
read 8 22 c3 0 8 0
read 1 23 0f 0 1 0
restart 5 00 77 0 5 0
read 4 31 81 0 4 0
restart 2 00 19 0 2 0
read 6 32 e4 0 6 0
overflow 11 00 6b 0 8 1
write 3 00 d2 0 3 0
zero-length 0 41 00 0 0 2
read 2 42 48 0 2 0
nack 6 51 99 2 2 3
nack 4 52 2e 1 1 3
write 0 00 00 0 0 0
read 5 53 f0 0 5 0
overflow 9 00 36 0 8 1
